/* arithPkg.sv */
package arithPkg;

	// ====================
	// widths
	// ====================
	localparam int coeffWidth = 30;
	localparam int laneWidth  = 32;   // coefficient is zero-extended into a lane

	// ====================
	// moduli
	// ====================
	localparam logic [coeffWidth-1:0] modQ1 = 30'd134250497;   // 2^27 + 2^15 + 1
	localparam logic [coeffWidth-1:0] modQ2 = 30'd536903681;   // 2^29 + 2^15 + 1

	// k is the bit length of q
	localparam int barrettK1 = 28;
	localparam int barrettK2 = 30;

	// mu = floor(2^2k / q)
	localparam logic [31:0] barrettMu1 = 32'd536739867;
	localparam logic [31:0] barrettMu2 = 32'd2147352579;

	typedef enum logic
	{
		MOD_Q1 = 1'b0,
		MOD_Q2 = 1'b1
	} modSel_e;

endpackage

/* barrettMul.sv */
module barrettMul import arithPkg::*;
(
	input  logic                  iSYS_CLK,
	input  logic                  iSYS_RST,
	input  logic                  issue,
	input  modSel_e               issueMod,
	input  logic [coeffWidth-1:0] opA,
	input  logic [coeffWidth-1:0] opB,
	output logic                  prodValid,
	output logic [coeffWidth-1:0] prod
);

	logic                    vld1;
	logic                    vld2;
	logic                    vld3;
	modSel_e                 mod1;
	modSel_e                 mod2;
	modSel_e                 mod3;
	modSel_e                 mod4;
	logic [2*coeffWidth-1:0] full1;
	logic [31:0]             low2;
	logic [coeffWidth-1:0]   quot2;
	logic [31:0]             rem3;
	logic [31:0]             shifted;
	logic [63:0]             estimate;
	logic [coeffWidth-1:0]   quotEst;
	logic [31:0]             qTimes;
	logic [31:0]             sub1;
	logic [31:0]             sub2;

	function automatic logic [coeffWidth-1:0] modValue(input modSel_e sel);
		return (sel == MOD_Q1) ? modQ1 : modQ2;
	endfunction

	// ====================
	// combinational stage logic
	// ====================
	always_comb
	begin
		if (mod1 == MOD_Q1)
		begin
			shifted  = 32'(full1 >> (barrettK1 - 1));
			estimate = shifted * barrettMu1;
			quotEst  = coeffWidth'(estimate >> (barrettK1 + 1));
		end
		else
		begin
			shifted  = 32'(full1 >> (barrettK2 - 1));
			estimate = shifted * barrettMu2;
			quotEst  = coeffWidth'(estimate >> (barrettK2 + 1));
		end
	end

	assign qTimes = quot2 * modValue(mod2);   // low 32 bits are enough, remainder < 3q
	assign sub1   = (rem3 >= modValue(mod3)) ? rem3 - modValue(mod3) : rem3;
	assign sub2   = (sub1 >= modValue(mod3)) ? sub1 - modValue(mod3) : sub1;

	// valid travels down the pipe
	always_ff @(posedge iSYS_CLK)
	begin
		if (!iSYS_RST)
		begin
			vld1      <= 1'b0;
			vld2      <= 1'b0;
			vld3      <= 1'b0;
			prodValid <= 1'b0;
		end
		else
		begin
			vld1      <= issue;
			vld2      <= vld1;
			vld3      <= vld2;
			prodValid <= vld3;
		end
	end

	always_ff @(posedge iSYS_CLK)
	begin
		full1 <= opA * opB;   // stage 1
		mod1  <= issueMod;
		low2  <= full1[31:0];   // stage 2
		quot2 <= quotEst;
		mod2  <= mod1;
		rem3  <= low2 - qTimes;   // stage 3
		mod3  <= mod2;
		prod  <= sub2[coeffWidth-1:0];   // stage 4
		mod4  <= mod3;
	end

	// the modulus that entered with the pair bounds the result
	prodReduced: assert property (@(posedge iSYS_CLK) disable iff (!iSYS_RST)
		prodValid |-> (prod < modValue(mod4)));

endmodule

/* coeffRam.sv */
module coeffRam import arithPkg::*, ctlPkg::*;
#(
	parameter int coeffCount = 16,
	localparam int addrWidth = ramAddrWidth(coeffCount)
)
(
	input  logic                    iSYS_CLK,
	input  logic                    ramWrite,
	input  logic [addrWidth-1:0]    ramAddr,
	input  logic [2*coeffWidth-1:0] ramWord,
	output logic [2*coeffWidth-1:0] ramRead
);

	// one word holds the upper and lower lane coefficient of a beat
	logic [2*coeffWidth-1:0] mem [coeffCount/2];

	always_ff @(posedge iSYS_CLK)
	begin
		if (ramWrite)
			mem[ramAddr] <= ramWord;
	end

	// registered read, one cycle behind the address
	always_ff @(posedge iSYS_CLK)
	begin
		ramRead <= mem[ramAddr];
	end

endmodule

/* ctlPkg.sv */
package ctlPkg;

	localparam int beatWidth = 64;   // two lanes per stream beat

	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,
		ST_LOAD = 2'd1,   // coefficients in
		ST_MULT = 2'd2    // operands in and products out
	} pwmState_e;

	// address bits for a memory of count/2 words
	function automatic int ramAddrWidth(input int count);
		return (count > 2) ? $clog2(count / 2) : 1;
	endfunction

endpackage

/* pwmDecode.sv */
module pwmDecode import arithPkg::*, ctlPkg::*;
#(
	parameter int coeffCount = 16,
	localparam int addrWidth = ramAddrWidth(coeffCount)
)
(
	input  logic                    iSYS_CLK,
	input  logic                    iSYS_RST,
	input  logic                    start,
	input  modSel_e                 modSel,
	input  logic                    inValid,
	output logic                    inReady,
	input  logic [beatWidth-1:0]    inData,
	output logic                    ramWrite,
	output logic [addrWidth-1:0]    ramAddr,
	output logic [2*coeffWidth-1:0] ramWord,
	input  logic [2*coeffWidth-1:0] ramRead,
	output logic                    issue,
	output modSel_e                 issueMod,
	output logic [coeffWidth-1:0]   upperA,
	output logic [coeffWidth-1:0]   upperB,
	output logic [coeffWidth-1:0]   lowerA,
	output logic [coeffWidth-1:0]   lowerB
);

	localparam int lastBeat = coeffCount / 2 - 1;

	pwmState_e            state;
	logic [addrWidth-1:0] beatCnt;
	modSel_e              modReg;
	logic                 accept;
	logic                 finalBeat;

	assign accept    = inValid & inReady;
	assign finalBeat = (beatCnt == addrWidth'(lastBeat));

	// ====================
	// memory side
	// ====================
	assign ramWrite = accept & (state == ST_LOAD);
	assign ramAddr  = beatCnt;   // load writes and mult reads share the beat index
	assign ramWord  = {inData[laneWidth +: coeffWidth], inData[0 +: coeffWidth]};

	// stored coefficient arrives with the registered operand
	assign upperA   = ramRead[coeffWidth +: coeffWidth];
	assign lowerA   = ramRead[0 +: coeffWidth];
	assign issueMod = modReg;

	// ====================
	// job FSM
	// ====================
	always_ff @(posedge iSYS_CLK)
	begin
		if (!iSYS_RST)
		begin
			state   <= ST_IDLE;
			inReady <= 1'b0;
			beatCnt <= '0;
			modReg  <= MOD_Q1;
			issue   <= 1'b0;
		end
		else
		begin
			issue <= accept & (state == ST_MULT);
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state   <= ST_LOAD;
						inReady <= 1'b1;
						modReg  <= modSel;   // held for the whole job
						beatCnt <= '0;
					end
				end
				ST_LOAD:
				begin
					if (accept)
					begin
						beatCnt <= finalBeat ? '0 : beatCnt + 1'b1;
						if (finalBeat)
							state <= ST_MULT;
					end
				end
				ST_MULT:
				begin
					if (accept)
					begin
						beatCnt <= finalBeat ? '0 : beatCnt + 1'b1;
						if (finalBeat)
						begin
							state   <= ST_IDLE;
							inReady <= 1'b0;
						end
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// operand lanes, aligned with the memory read
	always_ff @(posedge iSYS_CLK)
	begin
		if (accept && state == ST_MULT)
		begin
			upperB <= inData[laneWidth +: coeffWidth];
			lowerB <= inData[0 +: coeffWidth];
		end
	end

	idleNotReady: assert property (@(posedge iSYS_CLK) disable iff (!iSYS_RST)
		(state == ST_IDLE) |-> !inReady);

endmodule

/* pwmPatterns.txt */
// M <sel>: modulus select of a job, 0 for Q1 and 1 for Q2
// L <upper> <lower>: load coefficients, O <upper> <lower>: operands, all hex
M 0
L 8008000 0000001
L 1234567 7654321
L 0ABCDEF 5A5A5A5
L 8000000 0000000
O 8008000 0000003
O 7FFFFFF 1111111
O 0000000 8008000
O 3C3C3C3 6DB6DB6
M 1
L 20008000 1FFFFFFF
L 0000001 20000000
L 13579BD 2468ACE
L 20008000 0000002
O 20008000 20008000
O 1FFFFFFF 0000001
O 20007FFF 1ABCDEF
O 0000005 20008000

/* pwmResult.sv */
module pwmResult import arithPkg::*, ctlPkg::*;
#(
	parameter int coeffCount = 16,
	localparam int addrWidth = ramAddrWidth(coeffCount)
)
(
	input  logic                  iSYS_CLK,
	input  logic                  iSYS_RST,
	input  logic                  prodValid,
	input  logic [coeffWidth-1:0] upperProd,
	input  logic [coeffWidth-1:0] lowerProd,
	output logic                  outValid,
	output logic [beatWidth-1:0]  outData,
	output logic                  outLast,
	output logic                  done
);

	localparam int lastBeat = coeffCount / 2 - 1;

	logic [addrWidth-1:0] outCnt;
	logic                 finalBeat;

	assign finalBeat = prodValid && (outCnt == addrWidth'(lastBeat));

	// ====================
	// beat count and flags
	// ====================
	always_ff @(posedge iSYS_CLK)
	begin
		if (!iSYS_RST)
		begin
			outValid <= 1'b0;
			outLast  <= 1'b0;
			done     <= 1'b0;
			outCnt   <= '0;
		end
		else
		begin
			outValid <= prodValid;
			outLast  <= finalBeat;
			done     <= finalBeat;   // same beat as last
			if (prodValid)
				outCnt <= finalBeat ? '0 : outCnt + 1'b1;
		end
	end

	// padding bits stay zero
	always_ff @(posedge iSYS_CLK)
	begin
		if (prodValid)
			outData <= {laneWidth'(upperProd), laneWidth'(lowerProd)};
	end

	// no product may follow the last beat because the next job loads first
	lastEndsJob: assert property (@(posedge iSYS_CLK) disable iff (!iSYS_RST)
		outLast |-> outValid ##1 !outValid);

endmodule

/* pwmTop.f */
arithPkg.sv
ctlPkg.sv
coeffRam.sv
pwmDecode.sv
barrettMul.sv
pwmResult.sv
pwmTop.sv
tbPwmTop.sv

/* pwmTop.sv */
module pwmTop import arithPkg::*, ctlPkg::*;
#(
	parameter int coeffCount = 16,
	localparam int addrWidth = ramAddrWidth(coeffCount)
)
(
	input  logic                 iSYS_CLK,
	input  logic                 iSYS_RST,
	input  logic                 start,
	input  modSel_e              modSel,
	input  logic                 inValid,
	output logic                 inReady,
	input  logic [beatWidth-1:0] inData,
	output logic                 outValid,
	output logic [beatWidth-1:0] outData,
	output logic                 outLast,
	output logic                 done
);

	logic                    ramWrite;
	logic [addrWidth-1:0]    ramAddr;
	logic [2*coeffWidth-1:0] ramWord;
	logic [2*coeffWidth-1:0] ramRead;
	logic                    issue;
	modSel_e                 issueMod;
	logic [coeffWidth-1:0]   upperA;
	logic [coeffWidth-1:0]   upperB;
	logic [coeffWidth-1:0]   lowerA;
	logic [coeffWidth-1:0]   lowerB;
	logic                    prodValid;
	logic [coeffWidth-1:0]   upperProd;
	logic [coeffWidth-1:0]   lowerProd;

	pwmDecode #(.coeffCount(coeffCount)) decode
	(
		.iSYS_CLK (iSYS_CLK),
		.iSYS_RST (iSYS_RST),
		.start    (start),
		.modSel   (modSel),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.ramWrite (ramWrite),
		.ramAddr  (ramAddr),
		.ramWord  (ramWord),
		.ramRead  (ramRead),
		.issue    (issue),
		.issueMod (issueMod),
		.upperA   (upperA),
		.upperB   (upperB),
		.lowerA   (lowerA),
		.lowerB   (lowerB)
	);

	coeffRam #(.coeffCount(coeffCount)) coeffMem
	(
		.iSYS_CLK (iSYS_CLK),
		.ramWrite (ramWrite),
		.ramAddr  (ramAddr),
		.ramWord  (ramWord),
		.ramRead  (ramRead)
	);

	// ====================
	// lanes
	// ====================
	barrettMul upperMul
	(
		.iSYS_CLK  (iSYS_CLK),
		.iSYS_RST  (iSYS_RST),
		.issue     (issue),
		.issueMod  (issueMod),
		.opA       (upperA),
		.opB       (upperB),
		.prodValid (prodValid),
		.prod      (upperProd)
	);

	barrettMul lowerMul
	(
		.iSYS_CLK  (iSYS_CLK),
		.iSYS_RST  (iSYS_RST),
		.issue     (issue),
		.issueMod  (issueMod),
		.opA       (lowerA),
		.opB       (lowerB),
		.prodValid (),   // lanes run in lockstep, upper valid is used
		.prod      (lowerProd)
	);

	pwmResult #(.coeffCount(coeffCount)) result
	(
		.iSYS_CLK  (iSYS_CLK),
		.iSYS_RST  (iSYS_RST),
		.prodValid (prodValid),
		.upperProd (upperProd),
		.lowerProd (lowerProd),
		.outValid  (outValid),
		.outData   (outData),
		.outLast   (outLast),
		.done      (done)
	);

endmodule

/* tbPwmTop.sv */
module tbPwmTop import arithPkg::*, ctlPkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int coeffCount = 8;
	localparam int half       = coeffCount / 2;

	logic                 iSYS_CLK;
	logic                 iSYS_RST;
	logic                 start;
	modSel_e              modSel;
	logic                 inValid;
	logic                 inReady;
	logic [beatWidth-1:0] inData;
	logic                 outValid;
	logic [beatWidth-1:0] outData;
	logic                 outLast;
	logic                 done;

	modSel_e              jobSel[$];
	logic [beatWidth-1:0] loadBeats[$];
	logic [beatWidth-1:0] opBeats[$];
	logic [beatWidth-1:0] expBeats[$];   // expected output beats in operand order
	int                   acceptCycles[$];
	logic [7:0]           lfsr;
	int                   cycle;
	int                   outIdx;
	int                   doneCount;
	bit                   monitorOn;
	bit                   multPhase;

	pwmTop #(.coeffCount(coeffCount)) UUT
	(
		.iSYS_CLK (iSYS_CLK),
		.iSYS_RST (iSYS_RST),
		.start    (start),
		.modSel   (modSel),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.outValid (outValid),
		.outData  (outData),
		.outLast  (outLast),
		.done     (done)
	);

	always #2 iSYS_CLK = ~iSYS_CLK;

	// ====================
	// helpers
	// ====================
	task automatic abortRun();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic checkBeat(input string name, input logic [beatWidth-1:0] exp,
		input logic [beatWidth-1:0] act);
		if (act !== exp)
		begin
			$display("error at %0.1f ns: %s expected %h got %h", $realtime, name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("error at %0.1f ns: %s expected %b got %b", $realtime, name, exp, act);
			abortRun();
		end
	endtask

	task automatic verifyLatency(input int act);
		if (act != 6)
		begin
			$display("error at %0.1f ns: latency expected 6 got %0d", $realtime, act);
			abortRun();
		end
	endtask

	task automatic expectIdle();
		checkFlag("inReady", 1'b0, inReady);
		checkFlag("outValid", 1'b0, outValid);
		checkFlag("outLast", 1'b0, outLast);
		checkFlag("done", 1'b0, done);
	endtask

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic [coeffWidth-1:0] expectedLane(input logic [coeffWidth-1:0] a,
		input logic [coeffWidth-1:0] b, input modSel_e sel);
		logic [63:0] q;
		q = (sel == MOD_Q1) ? 64'(modQ1) : 64'(modQ2);
		return coeffWidth'((64'(a) * 64'(b)) % q);
	endfunction

	task automatic readPatterns();
		int          fd;
		int          code;
		int          sel;
		string       tag;
		string       rest;
		logic [31:0] up;
		logic [31:0] lo;
		fd = $fopen("pwmPatterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open pwmPatterns.txt");
			abortRun();
		end
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag[0] == "/")
				code = $fgets(rest, fd);   // rest of a comment line
			else if (tag == "M")
			begin
				code = $fscanf(fd, "%d", sel);
				if (code != 1)
				begin
					$display("pattern file has a bad modulus line");
					abortRun();
				end
				jobSel.push_back(sel ? MOD_Q2 : MOD_Q1);
			end
			else
			begin
				code = $fscanf(fd, "%h %h", up, lo);
				if (code != 2)
				begin
					$display("pattern file has a bad data line");
					abortRun();
				end
				if (tag == "L")
					loadBeats.push_back({2'b00, up[29:0], 2'b00, lo[29:0]});
				else if (tag == "O")
					opBeats.push_back({2'b00, up[29:0], 2'b00, lo[29:0]});
				else
				begin
					$display("pattern file has an unknown line tag %s", tag);
					abortRun();
				end
			end
		end
		$fclose(fd);
		if (jobSel.size() == 0 || loadBeats.size() != jobSel.size() * half
			|| opBeats.size() != jobSel.size() * half)
		begin
			$display("pattern file does not hold complete jobs");
			abortRun();
		end
	endtask

	// ====================
	// driver
	// ====================
	task automatic insertGap(input bit gaps);
		if (gaps)
		begin
			lfsr = lfsrNext(lfsr);
			if (lfsr[0])
			begin
				@(posedge iSYS_CLK);
				#1;
			end
		end
	endtask

	task automatic sendBeat(input logic [beatWidth-1:0] beat);
		int waitCnt;
		waitCnt = 0;
		inData  = beat;
		inValid = 1'b1;
		@(negedge iSYS_CLK);
		while (!inReady)
		begin
			waitCnt++;
			if (waitCnt > 20)
			begin
				$display("timeout while waiting for inReady");
				abortRun();
			end
			@(negedge iSYS_CLK);
		end
		@(posedge iSYS_CLK);   // beat transfers here
		#1;
		inValid = 1'b0;
	endtask

	task automatic runJob(input int j, input bit gaps);
		int                   target;
		int                   waitCnt;
		logic [beatWidth-1:0] ld;
		logic [beatWidth-1:0] op;
		checkFlag("inReady before start", 1'b0, inReady);
		target    = doneCount + 1;
		multPhase = 1'b0;
		modSel    = jobSel[j];
		start     = 1'b1;
		@(posedge iSYS_CLK);
		#1;
		start = 1'b0;
		for (int k = 0; k < half; k++)
		begin
			insertGap(gaps);
			sendBeat(loadBeats[j*half + k]);
		end
		multPhase = 1'b1;
		for (int k = 0; k < half; k++)
		begin
			ld = loadBeats[j*half + k];
			op = opBeats[j*half + k];
			expBeats.push_back({2'b00, expectedLane(ld[61:32], op[61:32], jobSel[j]),
				2'b00, expectedLane(ld[29:0], op[29:0], jobSel[j])});
			insertGap(gaps);
			sendBeat(op);
		end
		waitCnt = 0;
		while (doneCount < target)
		begin
			@(posedge iSYS_CLK);
			#1;
			waitCnt++;
			if (waitCnt > 40)
			begin
				$display("timeout while waiting for done of job %0d", j);
				abortRun();
			end
		end
		checkFlag("inReady after done", 1'b0, inReady);
	endtask

	// monitor samples outputs on the falling edge
	always @(negedge iSYS_CLK)
	begin
		if (monitorOn)
		begin
			cycle++;
			if (inValid && inReady && multPhase)
				acceptCycles.push_back(cycle);
			if (outValid && expBeats.size() == 0)
			begin
				$display("output beat appeared with no operand beat pending");
				abortRun();
			end
			else if (outValid)
			begin
				checkBeat("outData", expBeats.pop_front(), outData);
				verifyLatency(cycle - acceptCycles.pop_front());
				checkFlag("outLast", outIdx == half - 1, outLast);
				checkFlag("done", outIdx == half - 1, done);
				if (outIdx == half - 1)
				begin
					outIdx = 0;
					doneCount++;
				end
				else
					outIdx++;
			end
			else
			begin
				checkFlag("outLast", 1'b0, outLast);   // never without a beat
				checkFlag("done", 1'b0, done);
			end
		end
	end

	initial
	begin
		iSYS_CLK  = 1'b0;
		iSYS_RST  = 1'b0;
		start     = 1'b0;
		modSel    = MOD_Q1;
		inValid   = 1'b0;
		inData    = '0;
		lfsr      = 8'd89;
		cycle     = 0;
		outIdx    = 0;
		doneCount = 0;
		monitorOn = 1'b0;
		multPhase = 1'b0;
		readPatterns();
		for (int i = 0; i < 5; i++)
		begin
			@(posedge iSYS_CLK);
			#1;
			expectIdle();
		end
		iSYS_RST  = 1'b1;
		monitorOn = 1'b1;
		@(posedge iSYS_CLK);
		#1;
		expectIdle();
		// second pass repeats every job with stalls on inValid
		for (int pass = 0; pass < 2; pass++)
			for (int j = 0; j < jobSel.size(); j++)
				runJob(j, pass == 1);
		repeat (10) @(posedge iSYS_CLK);
		if (expBeats.size() == 0 && acceptCycles.size() == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("operand beats were left without an output beat");
			abortRun();
		end
	end

endmodule
